// File: icache.f
rtl/icache_pkg.sv
rtl/icache_tag_array.sv
rtl/icache_data_array.sv
rtl/icache_lru.sv
rtl/icache_miss_ctrl.sv
rtl/icache_fetch_pipe.sv
rtl/icache_top.sv
verification/icache_tb.sv

// File: Makefile
SIM      ?= verilator
FLAGS    ?= --binary --timing --assert -j 0
TOP      := icache_tb
FILELIST := icache.f
BUILD    := obj_dir
BIN      := $(BUILD)/V$(TOP)
LOG      := sim.log
SOURCES  := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@grep -q "RESULT: PASS" $(LOG) || (echo "No pass line found in $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD) $(LOG)

// File: verification/icache_tb.sv
`default_nettype none

module icache_tb;

  import icache_pkg::*;

  localparam int          ways_c             = 2;
  localparam int          clk_period_c       = 20;
  localparam int          directed_fetches_c = 26;
  localparam int          rand_fetches_c     = 24;
  localparam int          watchdog_cycles_c  = (directed_fetches_c + rand_fetches_c) * 40 + 100;
  localparam int          fill_limit_c       = 40;
  localparam logic [31:0] seed_c             = 32'd73766;
  localparam ptag_t       ptag_xor_c         = 20'h3c5a7;

  typedef enum logic [1:0] {
    exp_none,
    exp_hit,
    exp_miss
  } exp_kind_e;

  // Expected outputs for one cycle
  typedef struct packed {
    exp_kind_e kind;
    instr_t    data;
    miss_req_s req;
    logic      way;
  } expect_s;

  logic      clk_i;
  logic      reset_i;
  logic      fetch_v_i;
  vaddr_t    fetch_vaddr_i;
  logic      ready_o;
  ptag_t     ptag_i;
  instr_t    data_o;
  logic      data_v_o;
  logic      miss_v_o;
  miss_req_s miss_req_o;
  logic      miss_way_o;
  logic      fill_v_i;
  fill_pkt_s fill_pkt_i;
  logic      fill_done_i;

  // Reference model of the tag side
  ptag_t       model_tag [2][sets_c];
  logic        model_valid [2][sets_c];
  logic        model_lru [sets_c];
  expect_s     exp_q [4];
  int unsigned neg_cnt = 0;
  logic        miss_pending = 1'b0;
  ptag_t       pend_ptag;
  logic        fetch_missed;
  logic [31:0] stim_rng;
  int          check_errors = 0;
  int          other_errors = 0;

  icache_top #(.ways_p(ways_c)) u_dut (
    .clk_i, .reset_i, .fetch_v_i, .fetch_vaddr_i, .ready_o, .ptag_i,
    .data_o, .data_v_o, .miss_v_o, .miss_req_o, .miss_way_o,
    .fill_v_i, .fill_pkt_i, .fill_done_i
  );

  initial
  begin
    clk_i = 1'b0;
    forever #(clk_period_c / 2) clk_i = ~clk_i;
  end

  ////////////////////////////////////////////////////////////
  // Memory model and address helpers
  ////////////////////////////////////////////////////////////

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Instruction word stored at a physical address
  function automatic instr_t mem_word(input logic [31:0] paddr);
    return xorshift32(xorshift32(paddr ^ seed_c));
  endfunction

  function automatic vaddr_t make_vaddr(input ptag_t vtag, input index_t idx,
                                        input word_sel_t w);
    return {vtag, idx, w, 2'b00};
  endfunction

  function automatic ptag_t translate(input vaddr_t va);
    return va[vaddr_width_c-1:page_offset_width_c] ^ ptag_xor_c;
  endfunction

  task automatic flag_mismatch(input string name, input logic [63:0] got,
                               input logic [63:0] want);
    $display("CHECK FAILED at time %0t: %s got %0h expected %0h", $time, name, got, want);
    check_errors++;
  endtask

  // Looks up the model and updates it as the cache will
  task automatic predict_fetch(input vaddr_t va, input ptag_t ptag, output expect_s e);
    index_t    idx;
    word_sel_t wsel;
    logic      hit;
    logic      way;
    idx  = va[block_offset_width_c +: index_width_c];
    wsel = va[3:2];
    hit  = 1'b0;
    way  = 1'b0;
    e    = '0;
    for (int w = 0; w < 2; w++)
    begin
      if (model_valid[w][idx] && model_tag[w][idx] == ptag)
      begin
        hit = 1'b1;
        way = 1'(w);
      end
    end
    if (hit)
    begin
      e.kind = exp_hit;
      e.data = mem_word({ptag, idx, wsel, 2'b00});
    end
    else
    begin
      // Invalid ways go first, then the LRU way
      if (!model_valid[0][idx])
        way = 1'b0;
      else if (!model_valid[1][idx])
        way = 1'b1;
      else
        way = model_lru[idx];
      e.kind      = exp_miss;
      e.req.ptag  = ptag;
      e.req.index = idx;
      e.way       = way;
      model_tag[way][idx]   = ptag;
      model_valid[way][idx] = 1'b1;
    end
    model_lru[idx] = ~way;
  endtask

  ////////////////////////////////////////////////////////////
  // Cycle driver
  ////////////////////////////////////////////////////////////

  // The ptag of a fetch follows one cycle behind it
  task automatic drive_cycle(input logic do_fetch, input vaddr_t va, input ptag_t ptag);
    expect_s e;
    @(posedge clk_i);
    fetch_v_i     <= do_fetch;
    fetch_vaddr_i <= va;
    ptag_i        <= pend_ptag;
    pend_ptag = ptag;
    e = '0;
    // Right behind a miss the fetch is squashed
    if (do_fetch && !fetch_missed)
      predict_fetch(va, ptag, e);
    exp_q[2'(neg_cnt + 32'd2)] = e;
    fetch_missed = (e.kind == exp_miss);
  endtask

  task automatic fetch_addr(input vaddr_t va);
    drive_cycle(1'b1, va, translate(va));
  endtask

  task automatic idle_cycle();
    drive_cycle(1'b0, '0, '0);
  endtask

  task automatic wait_fill_done();
    int n;
    n = 0;
    do
    begin
      idle_cycle();
      @(negedge clk_i);
      n++;
    end while (!fill_done_i && n < fill_limit_c);
    if (!fill_done_i)
    begin
      $display("Fill engine never finished the outstanding miss at time %0t", $time);
      other_errors++;
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Fill engine
  ////////////////////////////////////////////////////////////

  initial
  begin : fill_engine
    miss_req_s   req;
    logic        way;
    fill_pkt_s   pkt;
    int          delay;
    logic [31:0] fill_rng;
    fill_v_i    = 1'b0;
    fill_pkt_i  = '0;
    fill_done_i = 1'b0;
    fill_rng    = xorshift32(seed_c);
    forever
    begin
      @(negedge clk_i);
      if (!reset_i && miss_v_o)
      begin
        req      = miss_req_o;
        way      = miss_way_o;
        fill_rng = xorshift32(fill_rng);
        delay    = 1 + int'(fill_rng % 32'd6);
        repeat (delay) @(posedge clk_i);
        for (int w = 0; w < words_per_block_c; w++)
        begin
          pkt = '0;
          pkt.op    = fill_op_data;
          pkt.index = req.index;
          pkt.way   = {1'b0, way};
          pkt.payload.data.word_sel = word_sel_t'(w);
          pkt.payload.data.instr    = mem_word({req.ptag, req.index, word_sel_t'(w), 2'b00});
          fill_v_i   <= 1'b1;
          fill_pkt_i <= pkt;
          @(posedge clk_i);
        end
        pkt = '0;
        pkt.op    = fill_op_tag;
        pkt.index = req.index;
        pkt.way   = {1'b0, way};
        pkt.payload.tag.valid = 1'b1;
        pkt.payload.tag.ptag  = req.ptag;
        fill_pkt_i <= pkt;
        @(posedge clk_i);
        fill_v_i    <= 1'b0;
        fill_done_i <= 1'b1;
        @(posedge clk_i);
        fill_done_i <= 1'b0;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Output checks
  ////////////////////////////////////////////////////////////

  always @(negedge clk_i)
  begin : check_outputs
    expect_s e;
    logic    ready_exp;
    e = exp_q[neg_cnt[1:0]];
    if (!reset_i)
    begin
      ready_exp = (e.kind != exp_miss) && !miss_pending;
      assert (ready_o === ready_exp)
      else flag_mismatch("ready_o", 64'(ready_o), 64'(ready_exp));
      assert (data_v_o === (e.kind == exp_hit))
      else flag_mismatch("data_v_o", 64'(data_v_o), 64'(e.kind == exp_hit));
      assert (miss_v_o === (e.kind == exp_miss))
      else flag_mismatch("miss_v_o", 64'(miss_v_o), 64'(e.kind == exp_miss));
      if (e.kind == exp_hit)
        assert (data_o === e.data)
        else flag_mismatch("data_o", 64'(data_o), 64'(e.data));
      if (e.kind == exp_miss)
      begin
        assert (miss_req_o === e.req)
        else flag_mismatch("miss_req_o", 64'(miss_req_o), 64'(e.req));
        assert (miss_way_o === e.way)
        else flag_mismatch("miss_way_o", 64'(miss_way_o), 64'(e.way));
      end
      // Ready comes back one cycle after the done strobe
      if (fill_done_i)
        miss_pending = 1'b0;
      if (e.kind == exp_miss)
        miss_pending = 1'b1;
    end
    neg_cnt++;
  end

  initial
  begin : watchdog
    #(watchdog_cycles_c * clk_period_c);
    $display("Timeout after %0d cycles with the run still going", watchdog_cycles_c);
    $display("Errors: %0d value checks, %0d other", check_errors, other_errors);
    $display("RESULT: FAIL");
    $finish;
  end

  ////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////

  initial
  begin : stimulus
    vaddr_t va_a;
    vaddr_t va_b;
    vaddr_t va;
    reset_i       = 1'b1;
    fetch_v_i     = 1'b0;
    fetch_vaddr_i = '0;
    ptag_i        = '0;
    pend_ptag     = '0;
    fetch_missed  = 1'b0;
    stim_rng      = seed_c;
    for (int i = 0; i < 4; i++)
      exp_q[i] = '0;
    for (int s = 0; s < sets_c; s++)
    begin
      model_valid[0][s] = 1'b0;
      model_valid[1][s] = 1'b0;
      model_lru[s]      = 1'b0;
    end
    repeat (8) @(posedge clk_i);
    reset_i <= 1'b0;

    // Cold miss, then every word of the block hits
    va_a = make_vaddr(20'h00001, 8'h00, 2'd0);
    fetch_addr(va_a);
    wait_fill_done();
    for (int w = 0; w < 4; w++)
    begin
      fetch_addr(make_vaddr(20'h00001, 8'h00, word_sel_t'(w)));
      idle_cycle();
      idle_cycle();
    end

    // Back-to-back hits over two blocks
    va_b = make_vaddr(20'h00002, 8'h23, 2'd1);
    fetch_addr(va_b);
    wait_fill_done();
    for (int i = 0; i < 8; i++)
    begin
      if (i % 2 == 0)
        fetch_addr(make_vaddr(20'h00001, 8'h00, word_sel_t'(i / 2)));
      else
        fetch_addr(make_vaddr(20'h00002, 8'h23, word_sel_t'(i / 2)));
    end
    idle_cycle();
    idle_cycle();

    // Miss with a hitting fetch right behind it
    fetch_addr(make_vaddr(20'h00005, 8'h31, 2'd2));
    fetch_addr(make_vaddr(20'h00001, 8'h00, 2'd1));
    wait_fill_done();
    fetch_addr(make_vaddr(20'h00005, 8'h31, 2'd2));
    idle_cycle();

    // Replacement at one set with three tags
    fetch_addr(make_vaddr(20'h00007, 8'h40, 2'd0));
    wait_fill_done();
    fetch_addr(make_vaddr(20'h00008, 8'h40, 2'd0));
    wait_fill_done();
    fetch_addr(make_vaddr(20'h00007, 8'h40, 2'd3));
    fetch_addr(make_vaddr(20'h00009, 8'h40, 2'd1));
    wait_fill_done();
    fetch_addr(make_vaddr(20'h00008, 8'h40, 2'd2));
    wait_fill_done();
    fetch_addr(make_vaddr(20'h00009, 8'h40, 2'd0));
    idle_cycle();
    idle_cycle();

    // Same virtual tag under another physical tag
    drive_cycle(1'b1, va_a, translate(va_a) ^ 20'h00100);
    wait_fill_done();
    fetch_addr(va_a);
    drive_cycle(1'b1, va_a, translate(va_a) ^ 20'h00100);
    idle_cycle();
    idle_cycle();

    // Random mix over two sets and three tags
    for (int i = 0; i < rand_fetches_c; i++)
    begin
      stim_rng = xorshift32(stim_rng);
      va = make_vaddr(ptag_t'(32'd1 + stim_rng % 32'd3), {7'b0010000, stim_rng[8]},
                      stim_rng[5:4]);
      fetch_addr(va);
      if (fetch_missed)
        wait_fill_done();
      else if (stim_rng[11:10] == 2'b00)
        idle_cycle();
    end

    repeat (4) idle_cycle();
    @(negedge clk_i);
    $display("Errors: %0d value checks, %0d other", check_errors, other_errors);
    if (check_errors == 0 && other_errors == 0)
      $display("RESULT: PASS");
    else
      $display("RESULT: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// File: rtl/icache_top.sv
`default_nettype none

module icache_top #(
  parameter int  ways_p       = 2,
  localparam int way_width_lp = $clog2(ways_p)
) (
  input  logic                     clk_i,
  input  logic                     reset_i,
  input  logic                     fetch_v_i,
  input  icache_pkg::vaddr_t       fetch_vaddr_i,
  output logic                     ready_o,
  input  icache_pkg::ptag_t        ptag_i,
  output icache_pkg::instr_t       data_o,
  output logic                     data_v_o,
  output logic                     miss_v_o,
  output icache_pkg::miss_req_s    miss_req_o,
  output logic [way_width_lp-1:0]  miss_way_o,
  input  logic                     fill_v_i,
  input  icache_pkg::fill_pkt_s    fill_pkt_i,
  input  logic                     fill_done_i
);

  import icache_pkg::*;

  // Array read port
  logic                                      rd_v;
  index_t                                    rd_index;
  ptag_t [ways_p-1:0]                        tags;
  logic [ways_p-1:0]                         valid;
  instr_t [ways_p-1:0][words_per_block_c-1:0] blocks;

  // Tag-verify results
  logic                    tv_v;
  logic                    tv_hit;
  logic [way_width_lp-1:0] tv_hit_way;
  logic [ways_p-1:0]       tv_way_valid;
  index_t                  tv_index;
  ptag_t                   tv_ptag;
  logic                    squash;
  logic [way_width_lp-1:0] victim_way;

  icache_tag_array #(.ways_p(ways_p)) u_tag_array (
    .clk_i, .reset_i,
    .rd_v_i(rd_v), .rd_index_i(rd_index),
    .fill_v_i, .fill_pkt_i,
    .tags_o(tags), .valid_o(valid)
  );

  icache_data_array #(.ways_p(ways_p)) u_data_array (
    .clk_i,
    .rd_v_i(rd_v), .rd_index_i(rd_index),
    .fill_v_i, .fill_pkt_i,
    .blocks_o(blocks)
  );

  icache_fetch_pipe #(.ways_p(ways_p)) u_fetch_pipe (
    .clk_i, .reset_i, .fetch_v_i, .fetch_vaddr_i, .ptag_i,
    .squash_i(squash), .tags_i(tags), .valid_i(valid), .blocks_i(blocks),
    .rd_v_o(rd_v), .rd_index_o(rd_index),
    .tv_v_o(tv_v), .tv_hit_o(tv_hit), .tv_hit_way_o(tv_hit_way),
    .tv_way_valid_o(tv_way_valid), .tv_index_o(tv_index), .tv_ptag_o(tv_ptag),
    .data_o, .data_v_o
  );

  // Hits in tag-verify refresh the tree of their set
  icache_lru #(.ways_p(ways_p)) u_lru (
    .clk_i, .reset_i,
    .index_i(tv_index), .hit_v_i(data_v_o), .hit_way_i(tv_hit_way),
    .fill_v_i, .fill_pkt_i,
    .victim_way_o(victim_way)
  );

  icache_miss_ctrl #(.ways_p(ways_p)) u_miss_ctrl (
    .clk_i, .reset_i,
    .tv_v_i(tv_v), .tv_hit_i(tv_hit), .tv_way_valid_i(tv_way_valid),
    .tv_index_i(tv_index), .tv_ptag_i(tv_ptag), .victim_way_i(victim_way),
    .fill_done_i,
    .ready_o, .squash_o(squash), .miss_v_o, .miss_req_o, .miss_way_o
  );

endmodule

`default_nettype wire

// File: rtl/icache_fetch_pipe.sv
`default_nettype none

module icache_fetch_pipe #(
  parameter int  ways_p       = 2,
  localparam int way_width_lp = $clog2(ways_p)
) (
  input  logic                            clk_i,
  input  logic                            reset_i,
  input  logic                            fetch_v_i,
  input  icache_pkg::vaddr_t              fetch_vaddr_i,
  input  icache_pkg::ptag_t               ptag_i,
  input  logic                            squash_i,
  input  icache_pkg::ptag_t [ways_p-1:0]  tags_i,
  input  logic [ways_p-1:0]               valid_i,
  input  icache_pkg::instr_t [ways_p-1:0][icache_pkg::words_per_block_c-1:0] blocks_i,
  output logic                            rd_v_o,
  output icache_pkg::index_t              rd_index_o,
  output logic                            tv_v_o,
  output logic                            tv_hit_o,
  output logic [way_width_lp-1:0]         tv_hit_way_o,
  output logic [ways_p-1:0]               tv_way_valid_o,
  output icache_pkg::index_t              tv_index_o,
  output icache_pkg::ptag_t               tv_ptag_o,
  output icache_pkg::instr_t              data_o,
  output logic                            data_v_o
);

  import icache_pkg::*;

  localparam int word_lsb_lp = block_offset_width_c - $bits(word_sel_t);

  // Tag-lookup stage
  logic                           tl_v_r;
  index_t                         tl_index_r;
  word_sel_t                      tl_word_r;
  logic [ways_p-1:0]              tl_hit;
  instr_t [words_per_block_c-1:0] tl_block;

  // Tag-verify stage
  logic                           tv_v_r;
  logic [ways_p-1:0]              tv_hit_r;
  word_sel_t                      tv_word_r;
  instr_t [words_per_block_c-1:0] tv_block_r;

  ////////////////////////////////////////////////////////////
  // Cycle 0, launch the array reads
  ////////////////////////////////////////////////////////////

  assign rd_v_o     = fetch_v_i;
  assign rd_index_o = fetch_vaddr_i[block_offset_width_c +: index_width_c];

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      tl_v_r <= 1'b0;
    else
      tl_v_r <= fetch_v_i;
  end

  always_ff @(posedge clk_i)
  begin
    if (fetch_v_i)
    begin
      tl_index_r <= rd_index_o;
      tl_word_r  <= fetch_vaddr_i[word_lsb_lp +: $bits(word_sel_t)];
    end
  end

  ////////////////////////////////////////////////////////////
  // Cycle 1, compare against the physical tag
  ////////////////////////////////////////////////////////////

  always_comb
  begin
    tl_block = '0;
    for (int w = 0; w < ways_p; w++)
    begin
      tl_hit[w] = valid_i[w] && (tags_i[w] == ptag_i);
      if (tl_hit[w])
        tl_block = tl_block | blocks_i[w];
    end
  end

  // A miss in tag-verify kills whatever sits behind it
  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      tv_v_r <= 1'b0;
    else
      tv_v_r <= tl_v_r && !squash_i;
  end

  always_ff @(posedge clk_i)
  begin
    if (tl_v_r)
    begin
      tv_hit_r       <= tl_hit;
      tv_way_valid_o <= valid_i;
      tv_index_o     <= tl_index_r;
      tv_ptag_o      <= ptag_i;
      tv_word_r      <= tl_word_r;
      tv_block_r     <= tl_block;
    end
  end

  ////////////////////////////////////////////////////////////
  // Cycle 2, word select and result
  ////////////////////////////////////////////////////////////

  always_comb
  begin
    tv_hit_way_o = '0;
    for (int w = 0; w < ways_p; w++)
    begin
      if (tv_hit_r[w])
        tv_hit_way_o = way_width_lp'(w);
    end
  end

  assign tv_v_o   = tv_v_r;
  assign tv_hit_o = |tv_hit_r;
  assign data_o   = tv_block_r[tv_word_r];
  assign data_v_o = tv_v_r && tv_hit_o;

endmodule

`default_nettype wire

// File: rtl/icache_miss_ctrl.sv
`default_nettype none

module icache_miss_ctrl #(
  parameter int  ways_p       = 2,
  localparam int way_width_lp = $clog2(ways_p)
) (
  input  logic                      clk_i,
  input  logic                      reset_i,
  input  logic                      tv_v_i,
  input  logic                      tv_hit_i,
  input  logic [ways_p-1:0]         tv_way_valid_i,
  input  icache_pkg::index_t        tv_index_i,
  input  icache_pkg::ptag_t         tv_ptag_i,
  input  logic [way_width_lp-1:0]   victim_way_i,
  input  logic                      fill_done_i,
  output logic                      ready_o,
  output logic                      squash_o,
  output logic                      miss_v_o,
  output icache_pkg::miss_req_s     miss_req_o,
  output logic [way_width_lp-1:0]   miss_way_o
);

  import icache_pkg::*;

  typedef enum logic {
    state_ready,
    state_miss
  } state_e;

  state_e                  state_r;
  state_e                  state_n;
  logic                    invalid_found;
  logic [way_width_lp-1:0] invalid_way;

  ////////////////////////////////////////////////////////////
  // Victim choice
  ////////////////////////////////////////////////////////////

  // Lowest invalid way wins, scan ends on way 0
  always_comb
  begin
    invalid_found = 1'b0;
    invalid_way   = '0;
    for (int w = ways_p - 1; w >= 0; w--)
    begin
      if (!tv_way_valid_i[w])
      begin
        invalid_found = 1'b1;
        invalid_way   = way_width_lp'(w);
      end
    end
  end

  assign miss_way_o = invalid_found ? invalid_way : victim_way_i;
  assign miss_req_o = '{ptag: tv_ptag_i, index: tv_index_i};

  ////////////////////////////////////////////////////////////
  // Ready and miss FSM
  ////////////////////////////////////////////////////////////

  assign miss_v_o = (state_r == state_ready) && tv_v_i && !tv_hit_i;
  assign squash_o = miss_v_o;
  assign ready_o  = (state_r == state_ready) && !miss_v_o;

  always_comb
  begin
    state_n = state_r;
    case (state_r)
      state_ready: if (miss_v_o) state_n = state_miss;
      state_miss:  if (fill_done_i) state_n = state_ready;
      default:     state_n = state_ready;
    endcase
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      state_r <= state_ready;
    else
      state_r <= state_n;
  end

endmodule

`default_nettype wire

// File: rtl/icache_lru.sv
`default_nettype none

module icache_lru #(
  parameter int  ways_p       = 2,
  localparam int way_width_lp = $clog2(ways_p)
) (
  input  logic                     clk_i,
  input  logic                     reset_i,
  input  icache_pkg::index_t       index_i,
  input  logic                     hit_v_i,
  input  logic [way_width_lp-1:0]  hit_way_i,
  input  logic                     fill_v_i,
  input  icache_pkg::fill_pkt_s    fill_pkt_i,
  output logic [way_width_lp-1:0]  victim_way_o
);

  import icache_pkg::*;

  // Heap order tree, node n has children 2n+1 and 2n+2
  logic [sets_c-1:0][ways_p-2:0] lru_r;
  logic                          fill_tag_v;
  logic [way_width_lp-1:0]       fill_way;

  // Follow the bits down to the least recently used leaf
  function automatic logic [way_width_lp-1:0] lru_encode(logic [ways_p-2:0] bits);
    logic [way_width_lp-1:0] way;
    int                      node;
    way  = '0;
    node = 0;
    for (int lvl = 0; lvl < way_width_lp; lvl++)
    begin
      way[way_width_lp-1-lvl] = bits[node];
      node = 2 * node + 1 + int'(bits[node]);
    end
    return way;
  endfunction

  // Point every node on the path away from the touched way
  function automatic logic [ways_p-2:0] lru_touch(logic [ways_p-2:0] bits,
                                                 logic [way_width_lp-1:0] way);
    logic [ways_p-2:0] next;
    int                node;
    next = bits;
    node = 0;
    for (int lvl = 0; lvl < way_width_lp; lvl++)
    begin
      next[node] = ~way[way_width_lp-1-lvl];
      node = 2 * node + 1 + int'(way[way_width_lp-1-lvl]);
    end
    return next;
  endfunction

  assign fill_tag_v   = fill_v_i && (fill_pkt_i.op == fill_op_tag);
  assign fill_way     = fill_pkt_i.way[way_width_lp-1:0];
  assign victim_way_o = lru_encode(lru_r[index_i]);

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      lru_r <= '0;
    else if (fill_tag_v)
      lru_r[fill_pkt_i.index] <= lru_touch(lru_r[fill_pkt_i.index], fill_way);
    else if (hit_v_i)
      lru_r[index_i] <= lru_touch(lru_r[index_i], hit_way_i);
  end

endmodule

`default_nettype wire

// File: rtl/icache_data_array.sv
`default_nettype none

module icache_data_array #(
  parameter int  ways_p       = 2,
  localparam int way_width_lp = $clog2(ways_p)
) (
  input  logic                   clk_i,
  input  logic                   rd_v_i,
  input  icache_pkg::index_t     rd_index_i,
  input  logic                   fill_v_i,
  input  icache_pkg::fill_pkt_s  fill_pkt_i,
  output icache_pkg::instr_t [ways_p-1:0][icache_pkg::words_per_block_c-1:0] blocks_o
);

  import icache_pkg::*;

  logic                    fill_data_v;
  logic [way_width_lp-1:0] fill_way;
  word_sel_t               fill_word;
  instr_t                  fill_instr;

  // Data packets carry a single word each
  assign fill_data_v = fill_v_i && (fill_pkt_i.op == fill_op_data);
  assign fill_way    = fill_pkt_i.way[way_width_lp-1:0];
  assign fill_word   = fill_pkt_i.payload.data.word_sel;
  assign fill_instr  = fill_pkt_i.payload.data.instr;

  ////////////////////////////////////////////////////////////
  // Block banks
  ////////////////////////////////////////////////////////////

  for (genvar w = 0; w < ways_p; w++)
  begin : g_bank
    instr_t [words_per_block_c-1:0] bank_mem [sets_c];
    logic                           wr_en;

    assign wr_en = fill_data_v && (fill_way == way_width_lp'(w));

    // Word write, whole block read
    always_ff @(posedge clk_i)
    begin
      if (wr_en)
        bank_mem[fill_pkt_i.index][fill_word] <= fill_instr;
      if (rd_v_i)
        blocks_o[w] <= bank_mem[rd_index_i];
    end
  end

endmodule

`default_nettype wire

// File: rtl/icache_tag_array.sv
`default_nettype none

module icache_tag_array #(
  parameter int  ways_p       = 2,
  localparam int way_width_lp = $clog2(ways_p)
) (
  input  logic                                clk_i,
  input  logic                                reset_i,
  input  logic                                rd_v_i,
  input  icache_pkg::index_t                  rd_index_i,
  input  logic                                fill_v_i,
  input  icache_pkg::fill_pkt_s               fill_pkt_i,
  output icache_pkg::ptag_t [ways_p-1:0]      tags_o,
  output logic [ways_p-1:0]                   valid_o
);

  import icache_pkg::*;

  logic                    fill_tag_v;
  logic [way_width_lp-1:0] fill_way;

  assign fill_tag_v = fill_v_i && (fill_pkt_i.op == fill_op_tag);
  assign fill_way   = fill_pkt_i.way[way_width_lp-1:0];

  ////////////////////////////////////////////////////////////
  // One tag bank and one valid vector per way
  ////////////////////////////////////////////////////////////

  for (genvar w = 0; w < ways_p; w++)
  begin : g_way
    ptag_t             tag_mem [sets_c];
    logic [sets_c-1:0] valid_r;
    logic              wr_en;

    assign wr_en = fill_tag_v && (fill_way == way_width_lp'(w));

    always_ff @(posedge clk_i)
    begin
      if (wr_en)
        tag_mem[fill_pkt_i.index] <= fill_pkt_i.payload.tag.ptag;
      if (rd_v_i)
        tags_o[w] <= tag_mem[rd_index_i];
    end

    // Valid bits and their read copy start out clear
    always_ff @(posedge clk_i)
    begin
      if (reset_i)
      begin
        valid_r    <= '0;
        valid_o[w] <= 1'b0;
      end
      else
      begin
        if (wr_en)
          valid_r[fill_pkt_i.index] <= fill_pkt_i.payload.tag.valid;
        if (rd_v_i)
          valid_o[w] <= valid_r[rd_index_i];
      end
    end
  end

endmodule

`default_nettype wire

// File: rtl/icache_pkg.sv
`default_nettype none

package icache_pkg;

  ////////////////////////////////////////////////////////////
  // Geometry
  ////////////////////////////////////////////////////////////

  localparam int vaddr_width_c        = 32;
  localparam int page_offset_width_c  = 12;
  localparam int block_offset_width_c = 4;

  // Index plus block offset spans exactly one 4 KB page
  localparam int index_width_c     = page_offset_width_c - block_offset_width_c;
  localparam int sets_c            = 1 << index_width_c;
  localparam int words_per_block_c = 4;

  // Fixes the way field of a fill packet
  localparam int max_ways_c = 4;

  ////////////////////////////////////////////////////////////
  // Address fields
  ////////////////////////////////////////////////////////////

  typedef logic [vaddr_width_c-1:0]                     vaddr_t;
  typedef logic [vaddr_width_c-page_offset_width_c-1:0] ptag_t;
  typedef logic [index_width_c-1:0]                     index_t;
  typedef logic [$clog2(words_per_block_c)-1:0]         word_sel_t;
  typedef logic [31:0]                                  instr_t;

  // Block address sent out on a miss
  typedef struct packed {
    ptag_t  ptag;
    index_t index;
  } miss_req_s;

  ////////////////////////////////////////////////////////////
  // Fill packets
  ////////////////////////////////////////////////////////////

  typedef enum logic {
    fill_op_data,
    fill_op_tag
  } fill_op_e;

  // One instruction word of the block
  typedef struct packed {
    word_sel_t word_sel;
    instr_t    instr;
  } fill_data_s;

  // Tag install, padded to the data payload width
  typedef struct packed {
    logic        valid;
    ptag_t       ptag;
    logic [12:0] pad;
  } fill_tag_s;

  // Same payload word, read according to op
  typedef union packed {
    fill_data_s data;
    fill_tag_s  tag;
  } fill_payload_u;

  typedef struct packed {
    fill_op_e                        op;
    index_t                          index;
    logic [$clog2(max_ways_c)-1:0]   way;
    fill_payload_u                   payload;
  } fill_pkt_s;

endpackage

`default_nettype wire
